/* common/cpu8_config.svh */
`ifndef CPU8_CONFIG_SVH
`define CPU8_CONFIG_SVH

// Bus widths
`define CPU8_DATA_W 8
`define CPU8_ADDR_W 16

// Start vector bytes, high byte first
`define CPU8_VEC_H 16'h0000
`define CPU8_VEC_L 16'h0001

// Register counts
`define CPU8_NUM_DREGS 8
`define CPU8_NUM_AREGS 4

// Full opcodes
`define CPU8_OP_NOP 8'h00
`define CPU8_OP_TAB 8'h08
`define CPU8_OP_LDI 8'h0A
`define CPU8_OP_CMP 8'h50

// Opcode prefixes, upper bits only
`define CPU8_OP_LDR 6'b0000_01
`define CPU8_OP_STR 6'b0000_11
`define CPU8_OP_TRB 4'h1
`define CPU8_OP_TRA 4'h2
`define CPU8_OP_TAR 4'h3
`define CPU8_OP_ALU 4'h4
`define CPU8_OP_BR 4'h5

// ALU operations, low opcode nibble
`define CPU8_ALU_ADD 4'h0
`define CPU8_ALU_SUB 4'h1
`define CPU8_ALU_AND 4'h2
`define CPU8_ALU_ORA 4'h3
`define CPU8_ALU_NOT 4'h4
`define CPU8_ALU_EOR 4'h5
`define CPU8_ALU_LSL 4'h6
`define CPU8_ALU_LSR 4'h7
`define CPU8_ALU_ROL 4'h8
`define CPU8_ALU_ROR 4'h9

// Branch conditions
`define CPU8_COND_ALW 2'b01
`define CPU8_COND_LT 2'b10
`define CPU8_COND_EQ 2'b11

`endif

/* common/cpu8_pkg.sv */
`include "cpu8_config.svh"

package cpu8_pkg;

	typedef logic [`CPU8_DATA_W-1:0] byte_t;
	typedef logic [`CPU8_ADDR_W-1:0] addr_t;

	// 0-7 data registers, 8-15 address register bytes, low byte first
	typedef logic [3:0] reg_sel_t;
	typedef logic [1:0] areg_sel_t;
	typedef logic [3:0] alu_op_t;

	typedef enum logic [3:0] {
		CLS_NOP,
		CLS_TAB,
		CLS_LDI,
		CLS_LDR,
		CLS_STR,
		CLS_TRB,
		CLS_TRA,
		CLS_TAR,
		CLS_ALU,
		CLS_CMP,
		CLS_BRREL,
		CLS_BRIND
	} inst_class_t;

	typedef enum logic [2:0] {
		ST_VEC_H,
		ST_VEC_L,
		ST_FETCH,
		ST_DECODE,
		ST_OPERAND,
		ST_MEM,
		ST_EXEC
	} seq_state_t;

endpackage

/* control/opcode_decode.sv */
`timescale 1ns/100ps
`include "cpu8_config.svh"

module opcode_decode (
	input cpu8_pkg::byte_t opcode,
	output cpu8_pkg::inst_class_t cls,
	output cpu8_pkg::reg_sel_t rsel,
	output cpu8_pkg::areg_sel_t areg,
	output cpu8_pkg::alu_op_t op,
	output logic [1:0] cond
);

	logic [3:0] hi;

	assign hi = opcode[7:4];
	assign rsel = opcode[3:0];
	assign areg = opcode[1:0];
	assign op = opcode[3:0];

	// Relative branch keeps its condition low, indirect one above the register
	assign cond = (opcode[3:2] == 2'b00) ? opcode[1:0] : opcode[3:2];

	always_comb begin
		cls = cpu8_pkg::CLS_NOP;
		if (opcode == `CPU8_OP_TAB) begin
			cls = cpu8_pkg::CLS_TAB;
		end else if (opcode == `CPU8_OP_LDI) begin
			cls = cpu8_pkg::CLS_LDI;
		end else if (opcode[7:2] == `CPU8_OP_LDR) begin
			cls = cpu8_pkg::CLS_LDR;
		end else if (opcode[7:2] == `CPU8_OP_STR) begin
			cls = cpu8_pkg::CLS_STR;
		end else if (hi == `CPU8_OP_TRB) begin
			cls = cpu8_pkg::CLS_TRB;
		end else if (hi == `CPU8_OP_TRA) begin
			cls = cpu8_pkg::CLS_TRA;
		end else if (hi == `CPU8_OP_TAR) begin
			cls = cpu8_pkg::CLS_TAR;
		end else if (hi == `CPU8_OP_ALU) begin
			if (opcode[3:0] <= `CPU8_ALU_ROR) begin
				cls = cpu8_pkg::CLS_ALU;
			end
		end else if (opcode == `CPU8_OP_CMP) begin
			cls = cpu8_pkg::CLS_CMP;
		end else if (hi == `CPU8_OP_BR) begin
			if (opcode[3:2] == 2'b00) begin
				cls = cpu8_pkg::CLS_BRREL;
			end else begin
				cls = cpu8_pkg::CLS_BRIND;
			end
		end
	end

endmodule

/* control/sequencer.sv */
`timescale 1ns/100ps
`include "cpu8_config.svh"

module sequencer (
	input logic clk,
	input logic rst,
	input cpu8_pkg::byte_t rdata,
	output cpu8_pkg::byte_t opcode,
	input cpu8_pkg::inst_class_t cls,
	input cpu8_pkg::areg_sel_t areg,
	input logic [1:0] cond,
	input cpu8_pkg::addr_t pointer,
	input logic eq_flag,
	input logic lt_flag,
	input cpu8_pkg::byte_t acc,
	output cpu8_pkg::addr_t addr,
	output logic rd,
	output logic wr,
	output cpu8_pkg::byte_t wdata,
	output logic a_load,
	output logic a_src,
	output logic b_load,
	output logic reg_write,
	output logic alu_exec,
	output logic cmp_exec,
	output cpu8_pkg::byte_t load_data
);

	cpu8_pkg::seq_state_t state;
	cpu8_pkg::addr_t pc;
	cpu8_pkg::byte_t opcode_q;
	cpu8_pkg::addr_t offset;
	logic [1:0] cnt;
	logic taken;
	logic in_exec;

	// Opcode is live off the bus while decoding, then held
	assign opcode = (state == cpu8_pkg::ST_DECODE) ? rdata : opcode_q;
	assign in_exec = (state == cpu8_pkg::ST_EXEC);
	assign load_data = rdata;
	assign wdata = acc;

	assign taken = (cond == `CPU8_COND_ALW) ||
		(cond == `CPU8_COND_LT && lt_flag) ||
		(cond == `CPU8_COND_EQ && eq_flag);

	// Strobes to the datapath
	assign a_load = in_exec && (cls == cpu8_pkg::CLS_LDI || cls == cpu8_pkg::CLS_LDR ||
		cls == cpu8_pkg::CLS_TRA);
	assign a_src = (cls == cpu8_pkg::CLS_TRA) || (cls == cpu8_pkg::CLS_TRB);
	assign b_load = in_exec && (cls == cpu8_pkg::CLS_TAB || cls == cpu8_pkg::CLS_TRB);
	assign reg_write = in_exec && (cls == cpu8_pkg::CLS_TAR);
	assign alu_exec = in_exec && (cls == cpu8_pkg::CLS_ALU);
	assign cmp_exec = in_exec && (cls == cpu8_pkg::CLS_CMP);

	// Bus drive
	always_comb begin
		rd = 1'b0;
		wr = 1'b0;
		addr = pc;
		case (state)
			cpu8_pkg::ST_VEC_H: begin
				rd = (cnt == 2'd1);
				addr = `CPU8_VEC_H;
			end
			cpu8_pkg::ST_VEC_L: begin
				rd = (cnt == 2'd0);
				addr = `CPU8_VEC_L;
			end
			cpu8_pkg::ST_FETCH: rd = 1'b1;
			cpu8_pkg::ST_OPERAND: begin
				rd = (cnt != 2'd2);
				addr = pc + 16'd1 + 16'(cnt);
			end
			cpu8_pkg::ST_MEM: begin
				rd = 1'b1;
				addr = pointer;
			end
			cpu8_pkg::ST_EXEC: begin
				wr = (cls == cpu8_pkg::CLS_STR);
				if (wr) begin
					addr = pointer;
				end
			end
			default: addr = pc;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= cpu8_pkg::ST_VEC_H;
			pc <= '0;
			cnt <= '0;
			opcode_q <= '0;
			offset <= '0;
		end else begin
			case (state)
				cpu8_pkg::ST_VEC_H: begin
					// One idle cycle out of reset, then the first read
					cnt <= cnt + 2'd1;
					if (cnt == 2'd1) begin
						cnt <= '0;
						state <= cpu8_pkg::ST_VEC_L;
					end
				end
				cpu8_pkg::ST_VEC_L: begin
					if (cnt == 2'd0) begin
						pc[15:8] <= rdata;
						cnt <= 2'd1;
					end else begin
						pc[7:0] <= rdata;
						cnt <= '0;
						state <= cpu8_pkg::ST_FETCH;
					end
				end
				cpu8_pkg::ST_FETCH: state <= cpu8_pkg::ST_DECODE;
				cpu8_pkg::ST_DECODE: begin
					opcode_q <= rdata;
					cnt <= '0;
					case (cls)
						cpu8_pkg::CLS_LDI, cpu8_pkg::CLS_BRREL: state <= cpu8_pkg::ST_OPERAND;
						cpu8_pkg::CLS_LDR: state <= cpu8_pkg::ST_MEM;
						default: state <= cpu8_pkg::ST_EXEC;
					endcase
				end
				cpu8_pkg::ST_OPERAND: begin
					// Branch offset arrives high byte first
					if (cls == cpu8_pkg::CLS_BRREL) begin
						cnt <= cnt + 2'd1;
						if (cnt == 2'd1) begin
							offset[15:8] <= rdata;
						end
						if (cnt == 2'd2) begin
							offset[7:0] <= rdata;
							state <= cpu8_pkg::ST_EXEC;
						end
					end else begin
						state <= cpu8_pkg::ST_EXEC;
					end
				end
				cpu8_pkg::ST_MEM: state <= cpu8_pkg::ST_EXEC;
				cpu8_pkg::ST_EXEC: begin
					state <= cpu8_pkg::ST_FETCH;
					case (cls)
						cpu8_pkg::CLS_LDI: pc <= pc + 16'd2;
						cpu8_pkg::CLS_BRREL: pc <= taken ? pc + 16'd2 + offset : pc + 16'd3;
						cpu8_pkg::CLS_BRIND: pc <= taken ? pointer : pc + 16'd1;
						default: pc <= pc + 16'd1;
					endcase
				end
				default: state <= cpu8_pkg::ST_FETCH;
			endcase
		end
	end

endmodule

/* dv/cpu8_sva.sv */
`timescale 1ns/100ps

module cpu8_sva (
	input logic clk,
	input logic rst,
	input cpu8_pkg::addr_t addr,
	input logic rd,
	input logic wr
);

	// Failure count, read by the testbench summary
	int fail_count = 0;

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst) !(rd && wr))
		else begin
			fail_count++;
			$error("rd and wr are high in the same cycle");
		end

	// Bus stays idle while reset is held
	idle_in_reset: assert property (@(posedge clk) !rst |-> (!rd && !wr))
		else begin
			fail_count++;
			$error("bus strobe active during reset");
		end

	addr_known: assert property (@(posedge clk) disable iff (!rst) (rd || wr) |-> !$isunknown(addr))
		else begin
			fail_count++;
			$error("addr unknown during a bus access");
		end

endmodule

bind cpu8_top cpu8_sva sva0 (.clk(clk), .rst(rst), .addr(addr), .rd(rd), .wr(wr));

/* dv/cpu8_tb.sv */
`timescale 1ns/100ps
`include "cpu8_config.svh"

module cpu8_tb;

	// All five tests together run for about 1600 cycles
	localparam int CYCLE_LIMIT = 2000;
	localparam logic [15:0] DONE_ADDR = 16'hFFF0;
	localparam logic [15:0] MARK_ADDR = 16'h2600;

	logic clk;
	logic rst;
	cpu8_pkg::addr_t addr;
	logic rd;
	logic wr;
	cpu8_pkg::byte_t wdata;
	cpu8_pkg::byte_t rdata;

	logic [7:0] mem [0:65535];
	cpu8_pkg::addr_t wr_addr_q [$];
	cpu8_pkg::byte_t wr_data_q [$];
	cpu8_pkg::addr_t exp_addr_q [$];
	cpu8_pkg::byte_t exp_data_q [$];
	cpu8_pkg::addr_t loc;
	int log_base;
	int cycles = 0;
	int errors;
	int checks;
	int seed;
	int sva_fails;

	cpu8_top dut0 (
		.clk(clk), .rst(rst), .addr(addr), .rd(rd), .wr(wr), .wdata(wdata), .rdata(rdata)
	);

	always #5 clk = ~clk;

	// Memory model with one cycle read latency, every write is logged
	always @(posedge clk) begin
		if (rd) begin
			rdata <= mem[addr];
		end
		if (wr) begin
			mem[addr] <= wdata;
			wr_addr_q.push_back(addr);
			wr_data_q.push_back(wdata);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic cpu8_pkg::byte_t alu_model(input cpu8_pkg::alu_op_t op,
		input cpu8_pkg::byte_t x, input cpu8_pkg::byte_t y);
		cpu8_pkg::byte_t r;
		logic [2:0] s;
		s = y[2:0];
		r = x;
		case (op)
			`CPU8_ALU_ADD: r = x + y;
			`CPU8_ALU_SUB: r = x - y;
			`CPU8_ALU_AND: r = x & y;
			`CPU8_ALU_ORA: r = x | y;
			`CPU8_ALU_NOT: r = ~x;
			`CPU8_ALU_EOR: r = x ^ y;
			`CPU8_ALU_LSL: r = x << s;
			`CPU8_ALU_LSR: r = x >> s;
			`CPU8_ALU_ROL: begin
				for (int k = 0; k < int'(s); k++) begin
					r = {r[6:0], r[7]};
				end
			end
			`CPU8_ALU_ROR: begin
				for (int k = 0; k < int'(s); k++) begin
					r = {r[0], r[7:1]};
				end
			end
			default: r = x;
		endcase
		return r;
	endfunction

	function automatic cpu8_pkg::byte_t reg_value(input int i);
		logic [3:0] n;
		n = 4'(i);
		return {n, ~n};
	endfunction

	function automatic logic done_written();
		if (wr_addr_q.size() <= log_base) begin
			return 1'b0;
		end
		return wr_addr_q[$] == DONE_ADDR;
	endfunction

	task automatic emit(input cpu8_pkg::byte_t b);
		mem[loc] = b;
		loc = loc + 16'd1;
	endtask

	task automatic emit_ldi(input cpu8_pkg::byte_t v);
		emit(`CPU8_OP_LDI);
		emit(v);
	endtask

	task automatic emit_store(input cpu8_pkg::areg_sel_t n);
		emit({`CPU8_OP_STR, n});
	endtask

	// Low byte through index 8+2n, high byte through 9+2n
	task automatic emit_set_areg(input cpu8_pkg::areg_sel_t n, input cpu8_pkg::addr_t p);
		emit_ldi(p[7:0]);
		emit({`CPU8_OP_TAR, 1'b1, n, 1'b0});
		emit_ldi(p[15:8]);
		emit({`CPU8_OP_TAR, 1'b1, n, 1'b1});
	endtask

	task automatic emit_branch(input logic [1:0] cond, input cpu8_pkg::addr_t off);
		emit({`CPU8_OP_BR, 2'b00, cond});
		emit(off[15:8]);
		emit(off[7:0]);
	endtask

	task automatic expect_write(input cpu8_pkg::addr_t a, input cpu8_pkg::byte_t d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	// Done marker, then a branch onto itself
	task automatic emit_finish();
		emit_set_areg(2'd3, DONE_ADDR);
		emit_ldi(8'hD0);
		emit_store(2'd3);
		expect_write(DONE_ADDR, 8'hD0);
		emit_branch(`CPU8_COND_ALW, 16'hFFFE);
	endtask

	task automatic enter_reset(input cpu8_pkg::addr_t start);
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 65536; i++) begin
			mem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		end
		mem[`CPU8_VEC_H] = start[15:8];
		mem[`CPU8_VEC_L] = start[7:0];
		exp_addr_q.delete();
		exp_data_q.delete();
		log_base = wr_addr_q.size();
		loc = start;
	endtask

	task automatic run_program();
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		while (!done_written()) begin
			@(negedge clk);
		end
	endtask

	task automatic check_writes(input string name);
		int n_got;
		n_got = wr_addr_q.size() - log_base;
		checks++;
		if (n_got != exp_addr_q.size()) begin
			errors++;
			$display("error at %0t: %s expected %0d writes, saw %0d", $time, name,
				exp_addr_q.size(), n_got);
		end
		for (int i = 0; i < exp_addr_q.size() && i < n_got; i++) begin
			checks++;
			if (wr_addr_q[log_base + i] != exp_addr_q[i] ||
				wr_data_q[log_base + i] != exp_data_q[i]) begin
				errors++;
				$display("error at %0t: %s write %0d was %h <= %h, expected %h <= %h", $time,
					name, i, wr_addr_q[log_base + i], wr_data_q[log_base + i],
					exp_addr_q[i], exp_data_q[i]);
			end
		end
	endtask

	// Taken path jumps over the fall-through block, both rejoin after it
	task automatic emit_rel_check(input logic [1:0] cond, input logic taken, input int id);
		cpu8_pkg::byte_t mark_taken;
		cpu8_pkg::byte_t mark_fall;
		mark_taken = 8'h80 + 8'(id);
		mark_fall = 8'h40 + 8'(id);
		emit_branch(cond, 16'd7);
		emit_ldi(mark_fall);
		emit_store(2'd0);
		emit_branch(`CPU8_COND_ALW, 16'd4);
		emit_ldi(mark_taken);
		emit_store(2'd0);
		expect_write(MARK_ADDR, taken ? mark_taken : mark_fall);
	endtask

	// a1 points 13 bytes ahead, at the taken block
	task automatic emit_ind_check(input logic [1:0] cond, input logic taken, input int id);
		cpu8_pkg::byte_t mark_taken;
		cpu8_pkg::byte_t mark_fall;
		mark_taken = 8'h80 + 8'(id);
		mark_fall = 8'h40 + 8'(id);
		emit_set_areg(2'd1, loc + 16'd13);
		emit({`CPU8_OP_BR, cond, 2'd1});
		emit_ldi(mark_fall);
		emit_store(2'd0);
		emit_branch(`CPU8_COND_ALW, 16'd4);
		emit_ldi(mark_taken);
		emit_store(2'd0);
		expect_write(MARK_ADDR, taken ? mark_taken : mark_fall);
	endtask

	task automatic emit_compare_case(input cpu8_pkg::byte_t a_val,
		input cpu8_pkg::byte_t b_val, input int id);
		emit_ldi(b_val);
		emit(`CPU8_OP_TAB);
		emit_ldi(a_val);
		emit(`CPU8_OP_CMP);
		emit_rel_check(`CPU8_COND_LT, a_val < b_val, id);
		emit_rel_check(`CPU8_COND_EQ, a_val == b_val, id + 1);
		emit_ind_check(`CPU8_COND_LT, a_val < b_val, id + 2);
		emit_ind_check(`CPU8_COND_EQ, a_val == b_val, id + 3);
	endtask

	task automatic test_startup();
		enter_reset(16'h0100);
		emit_set_areg(2'd0, 16'h2000);
		emit_ldi(8'h5A);
		emit_store(2'd0);
		expect_write(16'h2000, 8'h5A);
		emit_finish();
		run_program();
		check_writes("startup");
	endtask

	task automatic test_load_store();
		enter_reset(16'h0340);
		mem[16'h3456] = 8'hC3;
		mem[16'h5001] = 8'h3C;
		emit_set_areg(2'd0, 16'h2100);
		emit_ldi(8'h11);
		emit_store(2'd0);
		emit_set_areg(2'd0, 16'h4ABC);
		emit_ldi(8'hA7);
		emit_store(2'd0);
		emit_set_areg(2'd0, 16'h8001);
		emit_ldi(8'hFE);
		emit_store(2'd0);
		emit_set_areg(2'd2, 16'h2180);
		emit_set_areg(2'd1, 16'h3456);
		emit({`CPU8_OP_LDR, 2'd1});
		emit_store(2'd2);
		emit_set_areg(2'd3, 16'h5001);
		emit({`CPU8_OP_LDR, 2'd3});
		emit_store(2'd2);
		expect_write(16'h2100, 8'h11);
		expect_write(16'h4ABC, 8'hA7);
		expect_write(16'h8001, 8'hFE);
		expect_write(16'h2180, 8'hC3);
		expect_write(16'h2180, 8'h3C);
		emit_finish();
		run_program();
		check_writes("load_store");
	endtask

	task automatic test_alu();
		cpu8_pkg::byte_t a_val;
		cpu8_pkg::byte_t b_val;
		enter_reset(16'h0400);
		emit_set_areg(2'd0, 16'h2200);
		for (int p = 0; p < 4; p++) begin
			b_val = 8'($random(seed));
			a_val = 8'($random(seed));
			emit_ldi(b_val);
			emit(`CPU8_OP_TAB);
			for (int k = 0; k < 10; k++) begin
				emit_ldi(a_val);
				emit({`CPU8_OP_ALU, 4'(k)});
				emit_store(2'd0);
				expect_write(16'h2200, alu_model(4'(k), a_val, b_val));
			end
		end
		emit_finish();
		run_program();
		check_writes("alu");
	endtask

	task automatic test_transfers();
		cpu8_pkg::addr_t ptr;
		enter_reset(16'h0600);
		for (int i = 0; i < 16; i++) begin
			emit_ldi(reg_value(i));
			emit({`CPU8_OP_TAR, 4'(i)});
		end
		// a0 was built from the values of indices 8 and 9
		ptr = {reg_value(9), reg_value(8)};
		for (int i = 0; i < 16; i++) begin
			emit({`CPU8_OP_TRA, 4'(i)});
			emit_store(2'd0);
			expect_write(ptr, reg_value(i));
		end
		for (int i = 0; i < 16; i++) begin
			emit({`CPU8_OP_TRB, 4'(i)});
			emit_ldi(8'h00);
			emit({`CPU8_OP_ALU, `CPU8_ALU_ADD});
			emit_store(2'd0);
			expect_write(ptr, reg_value(i));
		end
		emit_finish();
		run_program();
		check_writes("transfers");
	endtask

	task automatic test_branches();
		enter_reset(16'h0800);
		emit_set_areg(2'd0, MARK_ADDR);
		emit_compare_case(8'h44, 8'h44, 0);
		emit_compare_case(8'h21, 8'h90, 4);
		emit_compare_case(8'hC8, 8'h35, 8);
		emit_rel_check(`CPU8_COND_ALW, 1'b1, 12);
		emit_ind_check(`CPU8_COND_ALW, 1'b1, 13);
		emit_finish();
		run_program();
		check_writes("branches");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		rdata = '0;
		errors = 0;
		checks = 0;
		log_base = 0;
		loc = '0;
		seed = 32'h2bf3_be2b;
		test_startup();
		test_load_store();
		test_alu();
		test_transfers();
		test_branches();
		sva_fails = dut0.sva0.fail_count;
		$display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
			sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the cpu8 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module cpu8_tb || exit 1
out=$(./obj_dir/Vcpu8_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* verilog/alu.sv */
`timescale 1ns/100ps
`include "cpu8_config.svh"

module alu (
	input logic clk,
	input logic rst,
	input cpu8_pkg::alu_op_t op,
	input logic exec,
	input logic cmp,
	input logic a_load,
	input logic a_src,
	input logic b_load,
	input cpu8_pkg::byte_t load_data,
	input cpu8_pkg::byte_t rbyte,
	output cpu8_pkg::byte_t a,
	output logic eq_flag,
	output logic lt_flag
);

	cpu8_pkg::byte_t b;
	cpu8_pkg::byte_t result;
	logic [2:0] sh;
	logic [15:0] rot_l;
	logic [15:0] rot_r;

	assign sh = b[2:0];
	// Doubled word so a plain shift gives the rotate
	assign rot_l = {a, a} << sh;
	assign rot_r = {a, a} >> sh;

	always_comb begin
		case (op)
			`CPU8_ALU_ADD: result = a + b;
			`CPU8_ALU_SUB: result = a - b;
			`CPU8_ALU_AND: result = a & b;
			`CPU8_ALU_ORA: result = a | b;
			`CPU8_ALU_NOT: result = ~a;
			`CPU8_ALU_EOR: result = a ^ b;
			`CPU8_ALU_LSL: result = a << sh;
			`CPU8_ALU_LSR: result = a >> sh;
			`CPU8_ALU_ROL: result = rot_l[15:8];
			`CPU8_ALU_ROR: result = rot_r[7:0];
			default: result = a;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			a <= '0;
			b <= '0;
			eq_flag <= 1'b0;
			lt_flag <= 1'b0;
		end else begin
			if (a_load) begin
				a <= a_src ? rbyte : load_data;
			end else if (exec) begin
				a <= result;
			end
			// TAB copies a, TRB takes the register byte
			if (b_load) begin
				b <= a_src ? rbyte : a;
			end
			if (cmp) begin
				eq_flag <= (a == b);
				lt_flag <= (a < b);
			end
		end
	end

endmodule

/* verilog/cpu8_top.sv */
`timescale 1ns/100ps

module cpu8_top (
	input logic clk,
	input logic rst,
	output cpu8_pkg::addr_t addr,
	output logic rd,
	output logic wr,
	output cpu8_pkg::byte_t wdata,
	input cpu8_pkg::byte_t rdata
);

	cpu8_pkg::byte_t opcode;
	cpu8_pkg::inst_class_t cls;
	cpu8_pkg::reg_sel_t rsel;
	cpu8_pkg::areg_sel_t areg;
	cpu8_pkg::alu_op_t op;
	logic [1:0] cond;
	cpu8_pkg::addr_t pointer;
	cpu8_pkg::byte_t rbyte;
	cpu8_pkg::byte_t acc;
	cpu8_pkg::byte_t load_data;
	logic eq_flag;
	logic lt_flag;
	logic a_load;
	logic a_src;
	logic b_load;
	logic reg_write;
	logic alu_exec;
	logic cmp_exec;

	sequencer u_seq (
		.clk(clk), .rst(rst), .rdata(rdata),
		.opcode(opcode), .cls(cls), .areg(areg), .cond(cond),
		.pointer(pointer), .eq_flag(eq_flag), .lt_flag(lt_flag), .acc(acc),
		.addr(addr), .rd(rd), .wr(wr), .wdata(wdata),
		.a_load(a_load), .a_src(a_src), .b_load(b_load), .reg_write(reg_write),
		.alu_exec(alu_exec), .cmp_exec(cmp_exec), .load_data(load_data)
	);

	opcode_decode u_dec (
		.opcode(opcode), .cls(cls), .rsel(rsel), .areg(areg), .op(op), .cond(cond)
	);

	register_file u_regs (
		.clk(clk), .rst(rst), .rsel(rsel), .wdata_in(acc), .write(reg_write),
		.rbyte(rbyte), .areg(areg), .pointer(pointer)
	);

	alu u_alu (
		.clk(clk), .rst(rst), .op(op), .exec(alu_exec), .cmp(cmp_exec),
		.a_load(a_load), .a_src(a_src), .b_load(b_load), .load_data(load_data),
		.rbyte(rbyte), .a(acc), .eq_flag(eq_flag), .lt_flag(lt_flag)
	);

endmodule

/* verilog/register_file.sv */
`timescale 1ns/100ps
`include "cpu8_config.svh"

module register_file (
	input logic clk,
	input logic rst,
	input cpu8_pkg::reg_sel_t rsel,
	input cpu8_pkg::byte_t wdata_in,
	input logic write,
	output cpu8_pkg::byte_t rbyte,
	input cpu8_pkg::areg_sel_t areg,
	output cpu8_pkg::addr_t pointer
);

	cpu8_pkg::byte_t dregs [`CPU8_NUM_DREGS];
	cpu8_pkg::addr_t aregs [`CPU8_NUM_AREGS];

	// Index bits for the address register half
	logic [1:0] asel;
	logic hi_byte;

	assign asel = rsel[2:1];
	assign hi_byte = rsel[0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `CPU8_NUM_DREGS; i++) begin
				dregs[i] <= '0;
			end
			for (int j = 0; j < `CPU8_NUM_AREGS; j++) begin
				aregs[j] <= '0;
			end
		end else if (write) begin
			if (!rsel[3]) begin
				dregs[rsel[2:0]] <= wdata_in;
			end else if (hi_byte) begin
				aregs[asel][15:8] <= wdata_in;
			end else begin
				aregs[asel][7:0] <= wdata_in;
			end
		end
	end

	// Byte read for TRA and TRB
	always_comb begin
		if (!rsel[3]) begin
			rbyte = dregs[rsel[2:0]];
		end else if (hi_byte) begin
			rbyte = aregs[asel][15:8];
		end else begin
			rbyte = aregs[asel][7:0];
		end
	end

	assign pointer = aregs[areg];

endmodule

/* vlog.f */
+incdir+common
common/cpu8_pkg.sv
verilog/alu.sv
verilog/register_file.sv
control/opcode_decode.sv
control/sequencer.sv
verilog/cpu8_top.sv
dv/cpu8_sva.sv
dv/cpu8_tb.sv
